/* verilog/execPkg.sv */
`default_nettype none

package execPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int dataW      = 32;
    localparam int tagW       = 4;
    localparam int nameW      = 5;
    localparam int branchTagW = 4;
    localparam int branchNumW = $clog2(branchTagW);
    localparam int axiAddrW   = 4;

    // JALR targets always land on an even address.
    localparam logic [dataW-1:0] jalrMask = 32'hFFFF_FFFE;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SLT   = 4'd3,
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        LUI   = 4'd10,
        AUIPC = 4'd11,
        JAL   = 4'd12,
        JALR  = 4'd13
    } aluOpE;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        aluOpE                 op;
        logic                  op1Ready;
        logic [tagW-1:0]       op1Tag;
        logic [dataW-1:0]      op1Data;
        logic                  op2Ready;
        logic [tagW-1:0]       op2Tag;
        logic [dataW-1:0]      op2Data;
        logic [tagW-1:0]       destTag;
        logic [nameW-1:0]      destName;
        logic [dataW-1:0]      instAddr;
        logic [branchTagW-1:0] branchMask;
    } issueS;

    typedef struct packed {
        logic                  valid;
        logic [tagW-1:0]       tag;
        logic [nameW-1:0]      name;
        logic [dataW-1:0]      data;
        logic [branchTagW-1:0] branchMask;
    } cdbS;

    typedef struct packed {
        logic             valid;
        logic [dataW-1:0] addr;
    } redirectS;

endpackage

`default_nettype wire

/* verilog/aluReservationStation.sv */
`timescale 1ns/1ns
`default_nettype none

module aluReservationStation #(
    parameter int rsDepth = 4
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  execPkg::issueS                 issue,
    input  logic                           issueValid,
    output logic                           issueReady,
    input  execPkg::cdbS                   cdb,
    input  logic                           misTaken,
    input  logic                           bFreeEn,
    input  logic [execPkg::branchNumW-1:0] bFreeNum,
    input  logic                           issueEn,
    output execPkg::issueS                 selected,
    output logic                           selValid
);
    import execPkg::*;

    localparam int idxW = (rsDepth > 1) ? $clog2(rsDepth) : 1;

    issueS            entries    [rsDepth];
    issueS            snooped    [rsDepth];
    issueS            incoming;
    logic [rsDepth-1:0] entryValid;
    logic [rsDepth-1:0] readyVec;
    logic [idxW-1:0]  entryAge   [rsDepth];

    logic             freeFound;
    logic [idxW-1:0]  allocIdx;
    logic             selFound;
    logic [idxW-1:0]  selIdx;
    logic [idxW-1:0]  selAge;
    logic [idxW:0]    validCount;
    logic [idxW:0]    remaining;
    logic             doAlloc;
    logic             doSel;

    // Fills waiting operands from the broadcast and drops a resolved branch bit.
    function automatic issueS applySnoop(input issueS e);
        issueS r;
        r = e;
        if (cdb.valid && !r.op1Ready && r.op1Tag == cdb.tag) begin
            r.op1Ready = 1'b1;
            r.op1Data  = cdb.data;
        end
        if (cdb.valid && !r.op2Ready && r.op2Tag == cdb.tag) begin
            r.op2Ready = 1'b1;
            r.op2Data  = cdb.data;
        end
        if (bFreeEn) begin
            r.branchMask[bFreeNum] = 1'b0;
        end
        return r;
    endfunction

    assign incoming = applySnoop(issue);

    always_comb begin
        for (int i = 0; i < rsDepth; i++) begin
            snooped[i]  = applySnoop(entries[i]);
            readyVec[i] = entryValid[i] && entries[i].op1Ready && entries[i].op2Ready;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Allocation and selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        freeFound  = 1'b0;
        allocIdx   = '0;
        selFound   = 1'b0;
        selIdx     = '0;
        selAge     = '1;
        validCount = '0;
        for (int i = 0; i < rsDepth; i++) begin
            if (!entryValid[i] && !freeFound) begin
                freeFound = 1'b1;
                allocIdx  = idxW'(i);
            end
            // Strict compare keeps the lower index on a tie.
            if (readyVec[i] && (!selFound || entryAge[i] < selAge)) begin
                selFound = 1'b1;
                selIdx   = idxW'(i);
                selAge   = entryAge[i];
            end
            validCount = validCount + entryValid[i];
        end
    end

    assign doSel      = selFound && issueEn && !misTaken;
    assign issueReady = freeFound && issueEn && !misTaken;
    assign doAlloc    = issueValid && issueReady;
    assign remaining  = validCount - {{idxW{1'b0}}, doSel};
    assign selValid   = doSel;
    assign selected   = entries[selIdx];

    always_ff @(posedge clk) begin
        for (int i = 0; i < rsDepth; i++) begin
            if (doAlloc && allocIdx == idxW'(i)) begin
                entries[i] <= incoming;
            end else begin
                entries[i] <= snooped[i];
            end
        end
    end

    // Age is the number of older live entries, so the oldest sits at zero.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryValid <= '0;
            for (int i = 0; i < rsDepth; i++) begin
                entryAge[i] <= '0;
            end
        end else if (misTaken) begin
            entryValid <= '0;
        end else begin
            for (int i = 0; i < rsDepth; i++) begin
                if (doSel && selIdx == idxW'(i)) begin
                    entryValid[i] <= 1'b0;
                end else if (doSel && entryValid[i] && entryAge[i] > selAge) begin
                    entryAge[i] <= entryAge[i] - 1'b1;
                end
                if (doAlloc && allocIdx == idxW'(i)) begin
                    entryValid[i] <= 1'b1;
                    entryAge[i]   <= remaining[idxW-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/aluExecute.sv */
`timescale 1ns/1ns
`default_nettype none

module aluExecute (
    input  logic                           clk,
    input  logic                           rstN,
    input  execPkg::issueS                 selected,
    input  logic                           selValid,
    input  logic                           misTaken,
    input  logic                           bFreeEn,
    input  logic [execPkg::branchNumW-1:0] bFreeNum,
    output execPkg::cdbS                   cdb,
    output execPkg::redirectS              redirect
);
    import execPkg::*;

    logic [dataW-1:0]      opA;
    logic [dataW-1:0]      opB;
    logic [dataW-1:0]      opSum;
    logic [4:0]            shamt;
    logic [dataW-1:0]      resData;
    logic [dataW-1:0]      jumpAddr;
    logic                  isJump;
    logic [branchTagW-1:0] maskNext;

    logic                  resValidQ;
    logic                  jumpValidQ;
    logic [tagW-1:0]       resTagQ;
    logic [nameW-1:0]      resNameQ;
    logic [dataW-1:0]      resDataQ;
    logic [branchTagW-1:0] resMaskQ;
    logic [dataW-1:0]      jumpAddrQ;

    assign opA   = selected.op1Data;
    assign opB   = selected.op2Data;
    assign opSum = opA + opB;
    assign shamt = opB[4:0];

    always_comb begin
        resData  = '0;
        jumpAddr = '0;
        isJump   = 1'b0;
        case (selected.op)
            ADD:   resData = opSum;
            SUB:   resData = opA - opB;
            SLL:   resData = opA << shamt;
            SLT:   resData = {{(dataW-1){1'b0}}, $signed(opA) < $signed(opB)};
            SLTU:  resData = {{(dataW-1){1'b0}}, opA < opB};
            XOR:   resData = opA ^ opB;
            SRL:   resData = opA >> shamt;
            SRA:   resData = $signed(opA) >>> shamt;
            OR:    resData = opA | opB;
            AND:   resData = opA & opB;
            LUI:   resData = opB;
            AUIPC: resData = opSum;
            JAL: begin
                isJump   = 1'b1;
                jumpAddr = opSum;
                resData  = opA + dataW'(4);
            end
            JALR: begin
                isJump   = 1'b1;
                jumpAddr = opSum & jalrMask;
                resData  = selected.instAddr + dataW'(4);
            end
            default: resData = '0;
        endcase
    end

    always_comb begin
        maskNext = selected.branchMask;
        if (bFreeEn) begin
            maskNext[bFreeNum] = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValidQ  <= 1'b0;
            jumpValidQ <= 1'b0;
        end else begin
            resValidQ  <= selValid && !misTaken;
            jumpValidQ <= selValid && !misTaken && isJump;
        end
    end

    always_ff @(posedge clk) begin
        if (selValid) begin
            resTagQ   <= selected.destTag;
            resNameQ  <= selected.destName;
            resDataQ  <= resData;
            resMaskQ  <= maskNext;
            jumpAddrQ <= jumpAddr;
        end
    end

    assign cdb = '{valid: resValidQ, tag: resTagQ, name: resNameQ,
                   data: resDataQ, branchMask: resMaskQ};
    assign redirect = '{valid: jumpValidQ, addr: jumpAddrQ};

endmodule

`default_nettype wire

/* verilog/execCsrBlock.sv */
`timescale 1ns/1ns
`default_nettype none

module execCsrBlock #(
    parameter int rsDepth = 4
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [execPkg::axiAddrW-1:0] awAddr,
    input  logic                         awValid,
    output logic                         awReady,
    input  logic [execPkg::dataW-1:0]    wData,
    input  logic [3:0]                   wStrb,
    input  logic                         wValid,
    output logic                         wReady,
    output logic [1:0]                   bResp,
    output logic                         bValid,
    input  logic                         bReady,
    input  logic [execPkg::axiAddrW-1:0] arAddr,
    input  logic                         arValid,
    output logic                         arReady,
    output logic [execPkg::dataW-1:0]    rData,
    output logic [1:0]                   rResp,
    output logic                         rValid,
    input  logic                         rReady,
    input  logic                         cdbValid,
    input  logic                         jumpValid,
    input  logic                         misTaken,
    output logic                         issueEn
);
    import execPkg::*;

    localparam int numCounters = 3;

    logic                                  writeAccept;
    logic                                  readAccept;
    logic                                  clearCounters;
    logic [numCounters-1:0]                events;
    logic [numCounters-1:0][dataW-1:0]     counts;
    logic [dataW-1:0]                      ctrlWord;
    logic [dataW-1:0]                      readWord;

    // Only one access is in flight, and a write wins a same-cycle tie.
    assign writeAccept = awValid && wValid && !bValid && !rValid;
    assign readAccept  = arValid && !writeAccept && !bValid && !rValid;
    assign awReady     = writeAccept;
    assign wReady      = writeAccept;
    assign arReady     = readAccept;
    assign bResp       = 2'b00;
    assign rResp       = 2'b00;

    assign clearCounters = writeAccept && awAddr[3:2] == 2'd0 && wStrb[0] && wData[1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bValid  <= 1'b0;
            rValid  <= 1'b0;
            issueEn <= 1'b1;
        end else begin
            if (writeAccept) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            if (readAccept) begin
                rValid <= 1'b1;
            end else if (rReady) begin
                rValid <= 1'b0;
            end
            if (writeAccept && awAddr[3:2] == 2'd0 && wStrb[0]) begin
                issueEn <= wData[0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Event counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign events = {misTaken, jumpValid, cdbValid};

    for (genvar c = 0; c < numCounters; c++) begin : gCount
        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                counts[c] <= '0;
            end else if (clearCounters) begin
                counts[c] <= '0;
            end else if (events[c] && counts[c] != '1) begin
                counts[c] <= counts[c] + 1'b1;
            end
        end
    end

    // Bits 7:4 report the station capacity.
    assign ctrlWord = {{(dataW-8){1'b0}}, 4'(rsDepth), 3'b000, issueEn};

    always_comb begin
        case (arAddr[3:2])
            2'd0:    readWord = ctrlWord;
            2'd1:    readWord = counts[0];
            2'd2:    readWord = counts[1];
            default: readWord = counts[2];
        endcase
    end

    always_ff @(posedge clk) begin
        if (readAccept) begin
            rData <= readWord;
        end
    end

endmodule

`default_nettype wire

/* verilog/aluCluster.sv */
`timescale 1ns/1ns
`default_nettype none

module aluCluster #(
    parameter int rsDepth = 4
) (
    input  logic                           clk,
    input  logic                           rstN,
    input  execPkg::issueS                 issue,
    input  logic                           issueValid,
    output logic                           issueReady,
    input  logic                           misTaken,
    input  logic                           bFreeEn,
    input  logic [execPkg::branchNumW-1:0] bFreeNum,
    output execPkg::cdbS                   cdb,
    output execPkg::redirectS              redirect,
    input  logic [execPkg::axiAddrW-1:0]   awAddr,
    input  logic                           awValid,
    output logic                           awReady,
    input  logic [execPkg::dataW-1:0]      wData,
    input  logic [3:0]                     wStrb,
    input  logic                           wValid,
    output logic                           wReady,
    output logic [1:0]                     bResp,
    output logic                           bValid,
    input  logic                           bReady,
    input  logic [execPkg::axiAddrW-1:0]   arAddr,
    input  logic                           arValid,
    output logic                           arReady,
    output logic [execPkg::dataW-1:0]      rData,
    output logic [1:0]                     rResp,
    output logic                           rValid,
    input  logic                           rReady
);
    import execPkg::*;

    issueS selected;
    logic  selValid;
    logic  issueEn;

    aluReservationStation #(.rsDepth(rsDepth)) u_station (
        .clk, .rstN, .issue, .issueValid, .issueReady, .cdb, .misTaken,
        .bFreeEn, .bFreeNum, .issueEn, .selected, .selValid
    );

    aluExecute u_execute (
        .clk, .rstN, .selected, .selValid, .misTaken, .bFreeEn, .bFreeNum,
        .cdb, .redirect
    );

    // The result bus and redirect double as the counter event strobes.
    execCsrBlock #(.rsDepth(rsDepth)) u_csr (
        .clk, .rstN, .awAddr, .awValid, .awReady, .wData, .wStrb, .wValid,
        .wReady, .bResp, .bValid, .bReady, .arAddr, .arValid, .arReady,
        .rData, .rResp, .rValid, .rReady,
        .cdbValid(cdb.valid), .jumpValid(redirect.valid), .misTaken, .issueEn
    );

endmodule

`default_nettype wire

/* verification/tbClockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

    always #20 clk = ~clk;

endmodule

`default_nettype wire

/* verification/aluClusterChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module aluClusterChecker #(
    parameter int n = 4
) (
    input logic                 clk,
    input logic                 rstN,
    input logic                 misTaken,
    input logic                 cdbValid,
    input logic                 redirectValid,
    input logic                 issueReady,
    input logic [n-1:0]         stationValid,
    input logic                 selValid,
    input execPkg::aluOpE       selOp
);
    import execPkg::*;

    // A kill empties the result register on the same edge.
    killDrainsCdb: assert property (@(posedge clk) disable iff (!rstN)
        misTaken |=> !cdbValid)
        else $error("cdb result seen in the cycle after a kill");

    fullBlocksIssue: assert property (@(posedge clk) disable iff (!rstN)
        (&stationValid) |-> !issueReady)
        else $error("issueReady high with a full station");

    redirectOnlyJump: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |-> $past(selValid && (selOp == JAL || selOp == JALR)))
        else $error("redirect without a jump result");

endmodule

bind aluCluster aluClusterChecker #(.n(rsDepth)) u_checker (
    .clk, .rstN, .misTaken, .cdbValid(cdb.valid), .redirectValid(redirect.valid),
    .issueReady, .stationValid(u_station.entryValid), .selValid,
    .selOp(selected.op)
);

`default_nettype wire

/* verification/aluClusterTb.sv */
`timescale 1ns/1ns
`default_nettype none

module aluClusterTb;
    import execPkg::*;

    typedef struct packed {
        aluOpE      op;
        logic [31:0] a;
        logic [31:0] b;
        logic       r1;
        logic [3:0] t1;
        logic       r2;
        logic [3:0] t2;
        logic [3:0] dest;
        logic [3:0] mask;
        logic       flush;
    } rowS;

    typedef struct packed {
        logic [3:0]  tag;
        logic [4:0]  name;
        logic [31:0] data;
        logic [3:0]  mask;
        int          cyc;
    } resS;

    localparam int numRows    = 27;
    localparam int cycleLimit = numRows * 8 + 200;

    logic clk, rstN;
    issueS issue;
    logic issueValid, issueReady, misTaken, bFreeEn;
    logic [branchNumW-1:0] bFreeNum;
    cdbS cdb;
    redirectS redirect;
    logic [3:0] awAddr, arAddr, wStrb;
    logic [31:0] wData, rData, rdVal;
    logic awValid, awReady, wValid, wReady, bValid, bReady;
    logic arValid, arReady, rValid, rReady;
    logic [1:0] bResp, rResp;

    rowS tbl [numRows];
    logic [31:0] tagVal [16];
    resS gotQ[$], expQ[$];
    logic [31:0] redQ[$], expRedQ[$];
    int seed = 71;
    int nRow, cyc, dispCyc, errors, checks, testNum;
    int expExec, expJump, expFlush;

    tbClockGen u_clock (.clk, .rstN);

    aluCluster #(.rsDepth(4)) u_aluCluster (.*);

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycleLimit) begin
            $display("Timeout: run passed %0d cycles without finishing", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rstN && cdb.valid)
            gotQ.push_back('{tag: cdb.tag, name: cdb.name, data: cdb.data,
                             mask: cdb.branchMask, cyc: cyc});
        if (rstN && redirect.valid)
            redQ.push_back(redirect.addr);
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic addRow(input aluOpE op, input logic [31:0] a, input logic [31:0] b,
                          input logic [3:0] t1, input logic [3:0] t2, input logic [3:0] dest,
                          input logic [3:0] mask, input logic flush);
        // A tag of zero marks a ready operand.
        tbl[nRow] = '{op: op, a: a, b: b, r1: (t1 == 0), t1: t1, r2: (t2 == 0), t2: t2,
                      dest: dest, mask: mask, flush: flush};
        nRow++;
    endtask

    function automatic logic [31:0] rowPc(input int idx);
        return 32'h0000_1000 + idx * 4;
    endfunction

    // Reference results written from the RV32I rules.
    function automatic logic [31:0] refResult(input aluOpE op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] pc);
        case (op)
            ADD, AUIPC: return a + b;
            SUB:   return a + ~b + 1;
            SLL:   return a << b[4:0];
            SLT:   return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 1 : 0;
            SLTU:  return (a < b) ? 1 : 0;
            XOR:   return a ^ b;
            SRL:   return a >> b[4:0];
            SRA:   return (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
            OR:    return a | b;
            AND:   return a & b;
            LUI:   return b;
            JAL:   return a + 4;
            JALR:  return pc + 4;
            default: return 0;
        endcase
    endfunction

    task automatic expectRow(input int idx, input logic [3:0] cleared);
        logic [31:0] a, b, res;
        a = tbl[idx].r1 ? tbl[idx].a : tagVal[tbl[idx].t1];
        b = tbl[idx].r2 ? tbl[idx].b : tagVal[tbl[idx].t2];
        res = refResult(tbl[idx].op, a, b, rowPc(idx));
        tagVal[tbl[idx].dest] = res;
        expQ.push_back('{tag: tbl[idx].dest, name: 5'(idx), data: res,
                         mask: tbl[idx].mask & ~cleared, cyc: 0});
        expExec++;
        if (tbl[idx].op == JAL || tbl[idx].op == JALR) begin
            expRedQ.push_back(tbl[idx].op == JALR ? ((a + b) & ~32'h1) : a + b);
            expJump++;
        end
    endtask

    task automatic dispatch(input int idx);
        @(posedge clk);
        issue <= '{op: tbl[idx].op, op1Ready: tbl[idx].r1, op1Tag: tbl[idx].t1,
                   op1Data: tbl[idx].a, op2Ready: tbl[idx].r2, op2Tag: tbl[idx].t2,
                   op2Data: tbl[idx].b, destTag: tbl[idx].dest, destName: 5'(idx),
                   instAddr: rowPc(idx), branchMask: tbl[idx].mask};
        issueValid <= 1'b1;
        do @(negedge clk); while (!issueReady);
        dispCyc = cyc;
        @(posedge clk);
        issueValid <= 1'b0;
        if (tbl[idx].flush) begin
            misTaken <= 1'b1;
            expFlush++;
            @(posedge clk);
            misTaken <= 1'b0;
        end
    endtask

    task automatic drain(input logic checkLatency);
        resS got, exp;
        while (gotQ.size() < expQ.size()) @(negedge clk);
        while (expQ.size() > 0) begin
            got = gotQ.pop_front();
            exp = expQ.pop_front();
            checkValue("cdb.tag", got.tag, exp.tag);
            checkValue("cdb.name", got.name, exp.name);
            checkValue("cdb.data", got.data, exp.data);
            checkValue("cdb.branchMask", got.mask, exp.mask);
            if (checkLatency)
                checkValue("cdb latency", got.cyc - dispCyc, 2);
        end
        checkValue("redirect count", redQ.size(), expRedQ.size());
        while (redQ.size() > 0 && expRedQ.size() > 0)
            checkValue("redirect.addr", redQ.pop_front(), expRedQ.pop_front());
    endtask

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        awAddr  <= addr;
        wData   <= data;
        awValid <= 1'b1;
        wValid  <= 1'b1;
        do @(negedge clk); while (!awReady);
        checkValue("wReady", wReady, 1);
        @(posedge clk);
        awValid <= 1'b0;
        wValid  <= 1'b0;
        do @(negedge clk); while (!bValid);
        checkValue("bResp", bResp, 0);
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        arAddr  <= addr;
        arValid <= 1'b1;
        do @(negedge clk); while (!arReady);
        @(posedge clk);
        arValid <= 1'b0;
        do @(negedge clk); while (!rValid);
        checkValue("rResp", rResp, 0);
        data = rData;
    endtask

    task automatic endTest(input string name);
        testNum++;
        $display("Test %0d %s finished, errors so far %0d", testNum, name, errors);
    endtask

    initial begin
        issue = '0;
        issueValid = 1'b0;
        misTaken = 1'b0;
        bFreeEn = 1'b0;
        bFreeNum = '0;
        {awAddr, arAddr, wData} = '0;
        wStrb = 4'hF;
        {awValid, wValid, arValid} = '0;
        bReady = 1'b1;
        rReady = 1'b1;
        cyc = 0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Stimulus table
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int i = 0; i < 12; i++)
            addRow(aluOpE'(i), $random(seed), $random(seed), 0, 0, 4'(i + 1), 4'(i), 0);
        addRow(SRA, 32'h8000_0000, 31, 0, 0, 1, 0, 0);
        addRow(SLT, 32'hFFFF_FFFF, 1, 0, 0, 2, 0, 0);
        addRow(SLTU, 32'hFFFF_FFFF, 1, 0, 0, 3, 0, 0);
        addRow(JAL, 32'h0000_2000, 32'h0000_0040, 0, 0, 4, 0, 0);
        addRow(JALR, 32'h0000_3001, 32'h0000_0010, 0, 0, 5, 0, 0);
        addRow(ADD, $random(seed), $random(seed), 0, 0, 5, 0, 0);
        addRow(XOR, 0, $random(seed), 5, 0, 6, 0, 0);
        addRow(SUB, 0, 32'h0000_1234, 6, 0, 7, 0, 0);
        for (int i = 0; i < 4; i++)
            addRow(OR, 0, 0, 14, 14, 4'(8 + i), 0, 0);
        addRow(ADD, 1, 2, 0, 0, 8, 0, 1);
        addRow(AND, 0, 32'h0F0F_0F0F, 11, 0, 9, 4'b0011, 0);
        addRow(ADD, $random(seed), $random(seed), 0, 0, 11, 0, 0);

        wait (rstN);
        checkValue("issueReady after reset", issueReady, 1);
        checkValue("cdb.valid after reset", cdb.valid, 0);

        for (int i = 0; i < 15; i++) begin
            expectRow(i, 0);
            dispatch(i);
            drain(1);
        end
        endTest("arithmetic and logic");

        for (int i = 15; i < 17; i++) begin
            expectRow(i, 0);
            dispatch(i);
            drain(1);
        end
        endTest("jumps");

        for (int i = 17; i < 20; i++) begin
            expectRow(i, 0);
            dispatch(i);
        end
        drain(0);
        endTest("operand wakeup");

        axiRead(4'h0, rdVal);
        checkValue("CTRL", rdVal, 32'h41);
        axiWrite(4'h0, 0);
        @(negedge clk);
        checkValue("issueReady with issue disabled", issueReady, 0);
        axiWrite(4'h0, 1);
        for (int i = 20; i < 24; i++)
            dispatch(i);
        @(negedge clk);
        checkValue("issueReady with full station", issueReady, 0);
        @(posedge clk);
        misTaken <= 1'b1;
        @(posedge clk);
        misTaken <= 1'b0;
        expFlush++;
        endTest("back-pressure");

        dispatch(24);
        repeat (4) @(negedge clk);
        checkValue("results after kill", gotQ.size(), 0);
        dispatch(25);
        @(posedge clk);
        bFreeEn  <= 1'b1;
        bFreeNum <= 2'd1;
        @(posedge clk);
        bFreeEn  <= 1'b0;
        expectRow(26, 0);
        expectRow(25, 4'b0010);
        dispatch(26);
        drain(0);
        endTest("kill and branch free");

        axiRead(4'h4, rdVal);
        checkValue("execCount", rdVal, expExec);
        axiRead(4'h8, rdVal);
        checkValue("jumpCount", rdVal, expJump);
        axiRead(4'hC, rdVal);
        checkValue("flushCount", rdVal, expFlush);
        axiWrite(4'h0, 3);
        for (int i = 1; i < 4; i++) begin
            axiRead(4'(i * 4), rdVal);
            checkValue("cleared counter", rdVal, 0);
        end
        endTest("event counters");

        $display("Tests %0d, checks %0d, errors %0d", testNum, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/execPkg.sv
verilog/aluReservationStation.sv
verilog/aluExecute.sv
verilog/execCsrBlock.sv
verilog/aluCluster.sv
verification/tbClockGen.sv
verification/aluClusterChecker.sv
verification/aluClusterTb.sv
